// File: project.f
hdl/stepper_pkg.sv
hdl/move_fifo.sv
hdl/step_gen.sv
hdl/stepper_config.sv
hdl/endstop_homing.sv
hdl/stepper_cmd.sv
hdl/motion_top.sv
testbench/motion_sva.sv
testbench/motion_checker.sv
testbench/tb_motion.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_motion
FILELIST ?= project.f
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/tb_motion.sv
`timescale 1ns/1ps

module tb_motion;
	import stepper_pkg::*;

	logic clk;
	logic reset;
	systime_t systime;
	cmd_t cmd;
	logic cmd_ready;
	logic [31:0] arg_data;
	logic cmd_done;
	logic [31:0] param_data;
	logic param_write;
	logic invol_req;
	logic invol_grant;
	logic [n_endstops-1:0] endstop_in;
	logic shutdown;
	logic [n_motors-1:0] step;
	logic [n_motors-1:0] dir;
	logic step_missed_clock;
	logic endstop_missed_clock;
	logic queue_overflow;

	integer seed;
	int cycles;
	int limit;
	int test_no;
	int err_start;
	systime_t last_t [n_motors];
	position_t pos_model [n_motors];

	motion_top i_dut (.*);

	motion_checker i_chk (
		.clk, .reset, .systime, .step, .param_data, .param_write, .cmd_done
	);

	bind motion_top motion_sva i_sva (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// The watchdog limit grows with every move that is queued
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Error: run stopped after %0d cycles without finishing", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (reset)
			systime <= '0;
		else
			systime <= systime + 32'd1;
	end

	// Reference model for the due time of step k of a move that starts from base
	function automatic systime_t step_time(systime_t base, interval_t iv, add_t add, int k);
		systime_t t;
		interval_t i;
		t = base;
		i = iv;
		for (int j = 0; j < k; j++) begin
			t = t + i;
			i = i + add;
		end
		return t;
	endfunction

	task automatic send_cmd(cmd_t code, int n, logic [31:0] a0, logic [31:0] a1,
		logic [31:0] a2, logic [31:0] a3);
		logic [31:0] args [4];
		int k;
		args = '{a0, a1, a2, a3};
		@(negedge clk);
		cmd = code;
		cmd_ready = 1'b1;
		arg_data = args[0];
		for (int i = 1; i < n; i++) begin
			@(negedge clk);
			cmd_ready = 1'b0;
			arg_data = args[i];
		end
		@(negedge clk);
		cmd_ready = 1'b0;
		arg_data = '0;
		for (k = 0; k < 200; k++) begin
			@(posedge clk);
			if (cmd_done)
				break;
		end
		if (k == 200)
			i_chk.report($sformatf("command 0x%02h never finished", code));
	endtask

	task automatic reset_clock(int m, systime_t t);
		send_cmd(cmd_reset_step_clock, 2, m, t, 0, 0);
		last_t[m] = t;
	endtask

	task automatic queue_move(int m, interval_t iv, count_t cnt, add_t add, logic predict);
		if (predict) begin
			for (int k = 1; k <= cnt; k++)
				i_chk.expect_step(m, step_time(last_t[m], iv, add, k));
			last_t[m] = step_time(last_t[m], iv, add, cnt);
		end
		limit += cnt * (iv + add * cnt) + 100;
		send_cmd(cmd_queue_step, 4, m, iv, cnt, add);
	endtask

	task automatic get_pos(int m);
		i_chk.expect_word(m);
		i_chk.expect_word(pos_model[m]);
		i_chk.expect_word(rsp_get_pos);
		send_cmd(cmd_get_pos, 1, m, 0, 0, 0);
	endtask

	task automatic wait_steps(int m);
		int k;
		for (k = 0; k < 100000; k++) begin
			@(posedge clk);
			if (i_chk.pending_steps(m) == 0)
				break;
		end
		if (k == 100000)
			i_chk.report($sformatf("motor %0d stopped stepping early", m));
		repeat (3) @(posedge clk);
	endtask

	// Waits for n more step events on a motor
	task automatic wait_events(int m, int n);
		int k;
		int start;
		start = i_chk.events[m];
		for (k = 0; k < 2000; k++) begin
			@(posedge clk);
			if (i_chk.events[m] - start >= n)
				break;
		end
		if (k == 2000)
			i_chk.report($sformatf("motor %0d made no steps", m));
	endtask

	task automatic start_test();
		test_no++;
		err_start = i_chk.errors;
	endtask

	task automatic end_test(string name);
		$display("test %0d %s: %0d errors", test_no, name, i_chk.errors - err_start);
	endtask

	initial begin
		logic [31:0] r;
		interval_t iv;
		count_t cnt;
		add_t add;
		int seen;
		int k;
		systime_t t_trig;
		seed = 32'ha937c3be;
		cycles = 0;
		limit = 4000;
		test_no = 0;
		reset = 1'b1;
		systime = '0;
		cmd = '0;
		cmd_ready = 1'b0;
		arg_data = '0;
		invol_grant = 1'b0;
		endstop_in = '0;
		shutdown = 1'b0;
		for (int m = 0; m < n_motors; m++) begin
			last_t[m] = '0;
			pos_model[m] = '0;
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		start_test();
		for (int m = 0; m < n_motors; m++) begin
			send_cmd(cmd_set_next_dir, 2, m, 1, 0, 0);
			reset_clock(m, systime + 40);
			for (int j = 0; j < 2; j++) begin
				r = $random(seed);
				iv = 40 + r[5:0];
				cnt = 2 + r[8:6];
				add = r[10:9];
				queue_move(m, iv, cnt, add, 1'b1);
				pos_model[m] += cnt;
			end
		end
		for (int m = 0; m < n_motors; m++) begin
			wait_steps(m);
			get_pos(m);
		end
		i_chk.check_value("dir", 32'h3, 32'(dir));
		end_test("random moves");

		start_test();
		send_cmd(cmd_set_next_dir, 2, 0, 0, 0, 0);
		reset_clock(0, systime + 40);
		cnt = pos_model[0] + 3;
		queue_move(0, 30, cnt, 0, 1'b1);
		pos_model[0] -= cnt;
		wait_steps(0);
		i_chk.check_value("dir[0]", 0, 32'(dir[0]));
		get_pos(0);
		end_test("reverse direction");

		start_test();
		i_chk.set_mode(1, 1'b1, 1'b1);
		send_cmd(cmd_config_stepper, 2, 1, 1, 0, 0);
		seen = i_chk.events[1];
		reset_clock(1, systime + 40);
		queue_move(1, 25, 5, 1, 1'b1);
		wait_steps(1);
		i_chk.check_value("toggle_count[1]", 5, i_chk.events[1] - seen);
		end_test("edge mode");

		start_test();
		i_chk.set_mode(0, 1'b0, 1'b0);
		send_cmd(cmd_endstop_set_stepper, 2, 0, 0, 0, 0);
		reset_clock(0, systime + 40);
		queue_move(0, 50, 1000, 0, 1'b0);
		send_cmd(cmd_endstop_home, 4, 0, systime + 30, 5, 1);
		wait_events(0, 2);
		@(negedge clk);
		endstop_in[0] = 1'b1;
		for (k = 0; k < 500; k++) begin
			@(posedge clk);
			if (invol_req)
				break;
		end
		if (k == 500)
			i_chk.report("invol_req did not rise after the endstop triggered");
		t_trig = systime;
		seen = i_chk.events[0];
		i_chk.expect_word(0);
		i_chk.expect_word(0);
		i_chk.expect_word(1);
		i_chk.expect_word(rsp_endstop_state);
		repeat (3) @(negedge clk);
		invol_grant = 1'b1;
		@(negedge clk);
		invol_grant = 1'b0;
		for (k = 0; k < 50; k++) begin
			@(posedge clk);
			if (cmd_done)
				break;
		end
		if (k == 50)
			i_chk.report("report frame never finished");
		repeat (150) @(posedge clk);
		i_chk.check_value("step_count[0]", seen, i_chk.events[0]);
		// Timed so that a move that got through would step inside the window below
		queue_move(0, systime + 60 - t_trig, 4, 0, 1'b0);
		repeat (150) @(posedge clk);
		i_chk.check_value("step_count[0]", seen, i_chk.events[0]);
		i_chk.set_mode(0, 1'b0, 1'b1);
		reset_clock(0, systime + 40);
		queue_move(0, 30, 3, 2, 1'b1);
		wait_steps(0);
		end_test("homing");

		start_test();
		i_chk.check_value("step_missed_clock", 0, 32'(step_missed_clock));
		i_chk.check_value("endstop_missed_clock", 0, 32'(endstop_missed_clock));
		reset_clock(1, systime - 100);
		queue_move(1, 10, 2, 0, 1'b0);
		repeat (10) @(posedge clk);
		i_chk.check_value("step_missed_clock", 1, 32'(step_missed_clock));
		send_cmd(cmd_endstop_home, 4, 1, systime - 50, 1, 0);
		repeat (5) @(posedge clk);
		i_chk.check_value("endstop_missed_clock", 1, 32'(endstop_missed_clock));
		end_test("missed time");

		// Motor 1 now waits on a due time far ahead, so its queue only fills
		start_test();
		for (int j = 0; j < move_depth; j++)
			queue_move(1, 10, 2, 0, 1'b0);
		i_chk.check_value("queue_overflow", 0, 32'(queue_overflow));
		queue_move(1, 10, 2, 0, 1'b0);
		i_chk.check_value("queue_overflow", 1, 32'(queue_overflow));
		end_test("queue overflow");

		start_test();
		@(negedge clk);
		i_chk.check_value("cmd_done", 0, 32'(cmd_done));
		cmd = 8'hee;
		cmd_ready = 1'b1;
		arg_data = 0;
		@(negedge clk);
		cmd_ready = 1'b0;
		i_chk.check_value("cmd_done", 1, 32'(cmd_done));
		i_chk.set_mode(0, 1'b0, 1'b0);
		reset_clock(0, systime + 40);
		queue_move(0, 30, 500, 0, 1'b0);
		wait_events(0, 2);
		@(negedge clk);
		shutdown = 1'b1;
		@(posedge clk);
		seen = i_chk.events[0];
		repeat (200) @(posedge clk);
		i_chk.check_value("step_count[0]", seen, i_chk.events[0]);
		end_test("unknown command and shutdown");

		i_chk.final_check();
		$display("%0d checks, %0d errors", i_chk.checks, i_chk.errors);
		if (i_chk.errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: testbench/motion_checker.sv
`timescale 1ns/1ps

module motion_checker (
	input logic clk,
	input logic reset,
	input stepper_pkg::systime_t systime,
	input logic [stepper_pkg::n_motors-1:0] step,
	input logic [31:0] param_data,
	input logic param_write,
	input logic cmd_done
);
	import stepper_pkg::*;

	int errors;
	int checks;
	int events [n_motors];
	systime_t exp_steps0 [$];
	systime_t exp_steps1 [$];
	logic [31:0] exp_words [$];
	logic [n_motors-1:0] toggle_mode;
	logic [n_motors-1:0] strict;
	logic [n_motors-1:0] prev_step;
	logic prev_write;

	initial begin
		errors = 0;
		checks = 0;
		toggle_mode = '0;
		strict = '1;
		prev_step = '0;
		prev_write = 1'b0;
		for (int m = 0; m < n_motors; m++)
			events[m] = 0;
	end

	task automatic report(string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
		end
	endtask

	task automatic expect_step(int m, systime_t t);
		if (m == 0)
			exp_steps0.push_back(t);
		else
			exp_steps1.push_back(t);
	endtask

	task automatic expect_word(logic [31:0] w);
		exp_words.push_back(w);
	endtask

	// Toggle mode counts every change of step, strict mode compares step times
	task automatic set_mode(int m, logic toggle_en, logic strict_en);
		toggle_mode[m] = toggle_en;
		strict[m] = strict_en;
	endtask

	function automatic int pending_steps(int m);
		return (m == 0) ? exp_steps0.size() : exp_steps1.size();
	endfunction

	task automatic take_step(int m);
		systime_t t;
		events[m]++;
		if (strict[m]) begin
			if (pending_steps(m) == 0) begin
				report($sformatf("step on motor %0d at systime %0d was not expected", m, systime));
			end else begin
				t = (m == 0) ? exp_steps0.pop_front() : exp_steps1.pop_front();
				check_value($sformatf("step_time[%0d]", m), t, systime);
			end
		end
	endtask

	task automatic final_check();
		for (int m = 0; m < n_motors; m++)
			if (pending_steps(m) != 0)
				report($sformatf("motor %0d still owes %0d steps", m, pending_steps(m)));
		if (exp_words.size() != 0)
			report($sformatf("%0d response words never arrived", exp_words.size()));
	endtask

	always @(posedge clk) begin
		if (reset) begin
			prev_step = '0;
			prev_write = 1'b0;
		end else begin
			for (int m = 0; m < n_motors; m++)
				if (toggle_mode[m] ? (step[m] != prev_step[m]) : (step[m] && !prev_step[m]))
					take_step(m);
			// The response code follows the last word, in the cycle param_write falls
			if (param_write || prev_write) begin
				if (exp_words.size() == 0)
					report($sformatf("response word 0x%08h came unasked", param_data));
				else
					check_value("param_data", exp_words.pop_front(), param_data);
				if (!param_write)
					check_value("cmd_done", 32'd1, 32'(cmd_done));
			end
			prev_step = step;
			prev_write = param_write;
		end
	end

endmodule

// File: testbench/motion_sva.sv
`timescale 1ns/1ps

module motion_sva (
	input logic clk,
	input logic reset,
	input logic cmd_ready,
	input logic cmd_done,
	input logic param_write,
	input logic invol_req,
	input logic invol_grant
);

	// cmd_done is a single cycle pulse
	a_done_pulse: assert property (@(posedge clk) disable iff (reset)
		cmd_done |=> !cmd_done) else $error("cmd_done held longer than one cycle");

	a_frame_end: assert property (@(posedge clk) disable iff (reset)
		$fell(param_write) |-> cmd_done) else $error("response frame ended without cmd_done");

	// A report request holds until it is granted
	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		invol_req && !invol_grant |=> invol_req) else $error("invol_req dropped before grant");

	a_no_cmd_during_req: assert property (@(posedge clk) disable iff (reset)
		!(invol_req && cmd_ready)) else $error("command issued while a report was pending");

endmodule

// File: hdl/motion_top.sv
`timescale 1ns/1ps

module motion_top (
	input logic clk,
	input logic reset,
	input stepper_pkg::systime_t systime,
	input stepper_pkg::cmd_t cmd,
	input logic cmd_ready,
	input logic [31:0] arg_data,
	output logic cmd_done,
	output logic [31:0] param_data,
	output logic param_write,
	output logic invol_req,
	input logic invol_grant,
	input logic [stepper_pkg::n_endstops-1:0] endstop_in,
	input logic shutdown,
	output logic [stepper_pkg::n_motors-1:0] step,
	output logic [stepper_pkg::n_motors-1:0] dir,
	output logic step_missed_clock,
	output logic endstop_missed_clock,
	output logic queue_overflow
);
	import stepper_pkg::*;

	logic [n_motors-1:0] push;
	logic [n_motors-1:0] pop;
	logic [n_motors-1:0] empty;
	logic [n_motors-1:0] full;
	logic [n_motors-1:0] stop;
	logic [n_motors-1:0] clock_set;
	logic [n_motors-1:0] missed;
	logic [n_motors-1:0] edge_mode;
	logic [n_motors-1:0] next_dir;
	logic [n_endstops-1:0][n_motors-1:0] link;
	logic [n_endstops-1:0] trigger;
	logic [n_endstops-1:0] homing;
	logic [n_endstops-1:0] pins;
	move_t move_data;
	move_t fifo_move [n_motors];
	position_t position [n_motors];
	systime_t clock_time;
	systime_t home_time;
	sample_t home_samples;
	logic home_we;
	logic home_pin;
	chan_t home_chan;
	logic cfg_we;
	logic [1:0] cfg_field;
	chan_t cfg_chan;
	chan_t cfg_index;
	logic cfg_value;

	stepper_cmd i_cmd (
		.clk, .reset, .cmd, .cmd_ready, .arg_data, .cmd_done,
		.param_data, .param_write, .invol_req, .invol_grant, .shutdown,
		.trigger, .link, .next_dir, .position, .homing, .pins, .full,
		.push, .move_data, .stop, .queue_overflow,
		.cfg_we, .cfg_field, .cfg_chan, .cfg_index, .cfg_value,
		.clock_set, .clock_time,
		.home_we, .home_chan, .home_time, .home_samples, .home_pin
	);

	stepper_config i_config (
		.clk, .reset, .cfg_we, .cfg_field, .cfg_chan, .cfg_index, .cfg_value,
		.edge_mode, .next_dir, .link
	);

	endstop_homing i_homing (
		.clk, .reset, .systime, .endstop_in,
		.home_we, .home_chan, .home_time, .home_samples, .home_pin,
		.trigger, .homing, .pins,
		.home_missed(endstop_missed_clock)
	);

	for (genvar m = 0; m < n_motors; m++) begin : g_motor
		// A stop flushes the queue in the same cycle that halts the generator
		move_fifo i_fifo (
			.clk, .reset,
			.flush(stop[m]),
			.push(push[m]),
			.move_data,
			.pop(pop[m]),
			.move(fifo_move[m]),
			.empty(empty[m]),
			.full(full[m])
		);

		step_gen i_step (
			.clk, .reset, .systime,
			.stop(stop[m]),
			.edge_mode(edge_mode[m]),
			.clock_set(clock_set[m]),
			.clock_time,
			.move(fifo_move[m]),
			.empty(empty[m]),
			.pop(pop[m]),
			.step(step[m]),
			.dir(dir[m]),
			.position(position[m]),
			.missed_clock(missed[m])
		);
	end

	assign step_missed_clock = |missed;

endmodule

// File: hdl/stepper_cmd.sv
`timescale 1ns/1ps

module stepper_cmd (
	input logic clk,
	input logic reset,
	input stepper_pkg::cmd_t cmd,
	input logic cmd_ready,
	input logic [31:0] arg_data,
	output logic cmd_done,
	output logic [31:0] param_data,
	output logic param_write,
	output logic invol_req,
	input logic invol_grant,
	input logic shutdown,
	input logic [stepper_pkg::n_endstops-1:0] trigger,
	input logic [stepper_pkg::n_endstops-1:0][stepper_pkg::n_motors-1:0] link,
	input logic [stepper_pkg::n_motors-1:0] next_dir,
	input stepper_pkg::position_t position [stepper_pkg::n_motors],
	input logic [stepper_pkg::n_endstops-1:0] homing,
	input logic [stepper_pkg::n_endstops-1:0] pins,
	input logic [stepper_pkg::n_motors-1:0] full,
	output logic [stepper_pkg::n_motors-1:0] push,
	output stepper_pkg::move_t move_data,
	output logic [stepper_pkg::n_motors-1:0] stop,
	output logic queue_overflow,
	output logic cfg_we,
	output logic [1:0] cfg_field,
	output stepper_pkg::chan_t cfg_chan,
	output stepper_pkg::chan_t cfg_index,
	output logic cfg_value,
	output logic [stepper_pkg::n_motors-1:0] clock_set,
	output stepper_pkg::systime_t clock_time,
	output logic home_we,
	output stepper_pkg::chan_t home_chan,
	output stepper_pkg::systime_t home_time,
	output stepper_pkg::sample_t home_samples,
	output logic home_pin
);
	import stepper_pkg::*;

	typedef enum logic [4:0] {
		s_idle,
		s_config,
		s_set_dir,
		s_link,
		s_queue_interval,
		s_queue_count,
		s_queue_add,
		s_reset_clock,
		s_pos_value,
		s_pos_code,
		s_query_homing,
		s_query_pin,
		s_query_code,
		s_home_time,
		s_home_samples,
		s_home_pin,
		s_wait_grant
	} cmd_state_t;

	cmd_state_t state;
	chan_t chan;
	interval_t q_interval;
	count_t q_count;
	add_t q_add;
	systime_t arg_time;
	logic [n_motors-1:0] discard;
	logic [n_endstops-1:0] pending;
	logic [n_endstops-1:0] grant_mask;
	chan_t grant_chan;

	// The channel stays put until the next command is accepted
	assign move_data = {next_dir[chan], q_interval, q_count, q_add};
	assign cfg_chan = chan;
	assign home_chan = chan;
	assign clock_time = arg_time;
	assign home_time = arg_time;

	always_comb begin
		for (int m = 0; m < n_motors; m++) begin
			stop[m] = shutdown;
			for (int e = 0; e < n_endstops; e++)
				stop[m] = stop[m] | (trigger[e] & link[e][m]);
		end
	end

	// Lowest pending endstop is reported first
	always_comb begin
		grant_chan = '0;
		for (int e = n_endstops - 1; e >= 0; e--)
			if (pending[e])
				grant_chan = chan_t'(e);
		grant_mask = '0;
		if (state == s_wait_grant && invol_grant)
			grant_mask[grant_chan] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			cmd_done <= 1'b0;
			param_data <= '0;
			param_write <= 1'b0;
			invol_req <= 1'b0;
			push <= '0;
			clock_set <= '0;
			cfg_we <= 1'b0;
			home_we <= 1'b0;
			discard <= '0;
			pending <= '0;
			queue_overflow <= 1'b0;
		end else begin
			cmd_done <= 1'b0;
			push <= '0;
			clock_set <= '0;
			cfg_we <= 1'b0;
			home_we <= 1'b0;
			// A stopped motor ignores moves until its clock is reset
			discard <= discard | stop;
			pending <= (pending | trigger) & ~grant_mask;

			case (state)
				s_idle: begin
					if (cmd_ready) begin
						chan <= chan_t'(arg_data);
						case (cmd)
							cmd_config_stepper: state <= s_config;
							cmd_set_next_dir: state <= s_set_dir;
							cmd_endstop_set_stepper: state <= s_link;
							cmd_queue_step: state <= s_queue_interval;
							cmd_reset_step_clock: state <= s_reset_clock;
							cmd_endstop_home: state <= s_home_time;
							cmd_get_pos: begin
								param_data <= 32'(chan_t'(arg_data));
								param_write <= 1'b1;
								state <= s_pos_value;
							end
							cmd_endstop_query: begin
								param_data <= 32'(chan_t'(arg_data));
								param_write <= 1'b1;
								state <= s_query_homing;
							end
							default: cmd_done <= 1'b1;
						endcase
					end else if (pending != '0) begin
						invol_req <= 1'b1;
						state <= s_wait_grant;
					end
				end
				s_config, s_set_dir, s_link: begin
					cfg_we <= 1'b1;
					cfg_field <= (state == s_config) ? field_edge :
						(state == s_set_dir) ? field_dir : field_link;
					cfg_value <= arg_data[0];
					cfg_index <= chan_t'(arg_data);
					cmd_done <= 1'b1;
					state <= s_idle;
				end
				s_queue_interval: begin
					q_interval <= arg_data;
					state <= s_queue_count;
				end
				s_queue_count: begin
					q_count <= arg_data;
					state <= s_queue_add;
				end
				s_queue_add: begin
					q_add <= arg_data;
					if (!discard[chan] && !stop[chan]) begin
						if (full[chan])
							queue_overflow <= 1'b1;
						else
							push[chan] <= 1'b1;
					end
					cmd_done <= 1'b1;
					state <= s_idle;
				end
				s_reset_clock: begin
					arg_time <= arg_data;
					clock_set[chan] <= 1'b1;
					discard[chan] <= 1'b0;
					cmd_done <= 1'b1;
					state <= s_idle;
				end
				s_pos_value: begin
					param_data <= position[chan];
					state <= s_pos_code;
				end
				s_pos_code: begin
					param_data <= rsp_get_pos;
					param_write <= 1'b0;
					cmd_done <= 1'b1;
					state <= s_idle;
				end
				s_query_homing: begin
					param_data <= 32'(homing[chan]);
					state <= s_query_pin;
				end
				s_query_pin: begin
					param_data <= 32'(pins[chan]);
					state <= s_query_code;
				end
				s_query_code: begin
					param_data <= rsp_endstop_state;
					param_write <= 1'b0;
					cmd_done <= 1'b1;
					state <= s_idle;
				end
				s_home_time: begin
					arg_time <= arg_data;
					state <= s_home_samples;
				end
				s_home_samples: begin
					home_samples <= sample_t'(arg_data);
					state <= s_home_pin;
				end
				s_home_pin: begin
					home_pin <= arg_data[0];
					home_we <= 1'b1;
					cmd_done <= 1'b1;
					state <= s_idle;
				end
				s_wait_grant: begin
					// The report reuses the endstop_query response frame
					if (invol_grant) begin
						invol_req <= 1'b0;
						chan <= grant_chan;
						param_data <= 32'(grant_chan);
						param_write <= 1'b1;
						state <= s_query_homing;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

// File: hdl/endstop_homing.sv
`timescale 1ns/1ps

module endstop_homing (
	input logic clk,
	input logic reset,
	input stepper_pkg::systime_t systime,
	input logic [stepper_pkg::n_endstops-1:0] endstop_in,
	input logic home_we,
	input stepper_pkg::chan_t home_chan,
	input stepper_pkg::systime_t home_time,
	input stepper_pkg::sample_t home_samples,
	input logic home_pin,
	output logic [stepper_pkg::n_endstops-1:0] trigger,
	output logic [stepper_pkg::n_endstops-1:0] homing,
	output logic [stepper_pkg::n_endstops-1:0] pins,
	output logic home_missed
);
	import stepper_pkg::*;

	typedef enum logic [1:0] {
		es_wait_time,
		es_rest,
		es_sample
	} es_state_t;

	es_state_t es_state [n_endstops];
	logic [n_endstops-1:0] pins_meta;
	systime_t start_time [n_endstops];
	sample_t samples [n_endstops];
	sample_t run [n_endstops];
	logic [n_endstops-1:0] expect_pin;
	logic [n_endstops-1:0] last_sample;
	logic [n_endstops-1:0] fire;

	// A run of matching samples completes on the sample that reaches the count
	always_comb begin
		for (int i = 0; i < n_endstops; i++) begin
			if (es_state[i] == es_rest)
				last_sample[i] = (samples[i] == sample_t'(1));
			else
				last_sample[i] = (run[i] + sample_t'(1) == samples[i]);
			fire[i] = homing[i] && (es_state[i] != es_wait_time)
				&& (pins[i] == expect_pin[i]) && last_sample[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			trigger <= '0;
			homing <= '0;
			home_missed <= 1'b0;
			for (int i = 0; i < n_endstops; i++)
				es_state[i] <= es_wait_time;
		end else begin
			trigger <= '0;
			for (int i = 0; i < n_endstops; i++) begin
				if (fire[i]) begin
					trigger[i] <= 1'b1;
					homing[i] <= 1'b0;
					es_state[i] <= es_wait_time;
				end else if (homing[i]) begin
					case (es_state[i])
						es_wait_time: begin
							if (systime == start_time[i])
								es_state[i] <= es_rest;
						end
						es_rest: begin
							if (pins[i] == expect_pin[i]) begin
								run[i] <= sample_t'(1);
								es_state[i] <= es_sample;
							end
						end
						es_sample: begin
							if (pins[i] != expect_pin[i])
								es_state[i] <= es_rest;
							else
								run[i] <= run[i] + sample_t'(1);
						end
						default: es_state[i] <= es_wait_time;
					endcase
				end
			end
			// A zero sample count cancels homing on that endstop
			if (home_we) begin
				homing[home_chan] <= (home_samples != '0);
				es_state[home_chan] <= es_wait_time;
				if (home_samples != '0 && time_past(home_time, systime))
					home_missed <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		pins_meta <= endstop_in;
		pins <= pins_meta;
		if (home_we) begin
			start_time[home_chan] <= home_time;
			samples[home_chan] <= home_samples;
			expect_pin[home_chan] <= home_pin;
		end
	end

endmodule

// File: hdl/stepper_config.sv
`timescale 1ns/1ps

module stepper_config (
	input logic clk,
	input logic reset,
	input logic cfg_we,
	input logic [1:0] cfg_field,
	input stepper_pkg::chan_t cfg_chan,
	input stepper_pkg::chan_t cfg_index,
	input logic cfg_value,
	output logic [stepper_pkg::n_motors-1:0] edge_mode,
	output logic [stepper_pkg::n_motors-1:0] next_dir,
	output logic [stepper_pkg::n_endstops-1:0][stepper_pkg::n_motors-1:0] link
);
	import stepper_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			edge_mode <= '0;
			next_dir <= '0;
			link <= '0;
		end else if (cfg_we) begin
			case (cfg_field)
				field_edge: edge_mode[cfg_chan] <= cfg_value;
				field_dir: next_dir[cfg_chan] <= cfg_value;
				// For links cfg_chan names the endstop and cfg_index the motor
				field_link: link[cfg_chan][cfg_index] <= 1'b1;
				default: ;
			endcase
		end
	end

endmodule

// File: hdl/step_gen.sv
`timescale 1ns/1ps

module step_gen (
	input logic clk,
	input logic reset,
	input stepper_pkg::systime_t systime,
	input logic stop,
	input logic edge_mode,
	input logic clock_set,
	input stepper_pkg::systime_t clock_time,
	input stepper_pkg::move_t move,
	input logic empty,
	output logic pop,
	output logic step,
	output logic dir,
	output stepper_pkg::position_t position,
	output logic missed_clock
);
	import stepper_pkg::*;

	typedef enum logic [1:0] {
		sg_idle,
		sg_load,
		sg_wait_due
	} sg_state_t;

	sg_state_t state;
	// Holds the due time of the pending step, and the last step time once idle
	systime_t last_time;
	interval_t interval;
	add_t add;
	count_t remaining;
	logic toggle;
	logic hit;
	logic next_late;
	systime_t next_due;

	assign pop = (state == sg_idle) && !empty && !stop;
	assign hit = (state == sg_wait_due) && (systime == last_time) && !stop;
	assign step = edge_mode ? (toggle ^ hit) : hit;
	assign next_due = last_time + interval;

	// The new due time is seen from the next cycle on, so compare one tick ahead
	assign next_late = time_past(next_due, systime + 32'd1);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sg_idle;
			last_time <= '0;
			dir <= 1'b0;
			position <= '0;
			toggle <= 1'b0;
			missed_clock <= 1'b0;
		end else begin
			if (clock_set)
				last_time <= clock_time;
			if (stop) begin
				state <= sg_idle;
			end else begin
				case (state)
					sg_idle: begin
						if (pop) begin
							dir <= move[96];
							// Moves with no steps are dropped right away
							if (move[63:32] != '0)
								state <= sg_load;
						end
					end
					sg_load: begin
						last_time <= next_due;
						if (next_late)
							missed_clock <= 1'b1;
						state <= sg_wait_due;
					end
					sg_wait_due: begin
						if (hit) begin
							position <= dir ? position + position_t'(1) : position - position_t'(1);
							toggle <= toggle ^ edge_mode;
							if (remaining == count_t'(1)) begin
								state <= sg_idle;
							end else begin
								last_time <= next_due;
								if (next_late)
									missed_clock <= 1'b1;
							end
						end
					end
					default: state <= sg_idle;
				endcase
			end
		end
	end

	// Move fields, the interval grows by add each time a due time is computed
	always_ff @(posedge clk) begin
		if (pop) begin
			interval <= move[95:64];
			remaining <= move[63:32];
			add <= move[31:0];
		end else if (state == sg_load || hit) begin
			interval <= interval + add;
			if (hit)
				remaining <= remaining - 1'b1;
		end
	end

endmodule

// File: hdl/move_fifo.sv
`timescale 1ns/1ps

module move_fifo (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic push,
	input stepper_pkg::move_t move_data,
	input logic pop,
	output stepper_pkg::move_t move,
	output logic empty,
	output logic full
);
	import stepper_pkg::*;

	move_t mem [move_depth];
	logic [move_ptr_w-1:0] wr_ptr;
	logic [move_ptr_w-1:0] rd_ptr;
	logic [move_ptr_w:0] used;
	logic do_push;
	logic do_pop;

	assign empty = (used == '0);
	// Depth is a power of two, so the top bit of the fill count means full
	assign full = used[move_ptr_w];
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Show-ahead output, the head entry is presented without a read cycle
	assign move = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= move_data;
	end

endmodule

// File: hdl/stepper_pkg.sv
package stepper_pkg;

	// Channel counts
	localparam int n_motors = 2;
	localparam int n_endstops = 2;

	typedef logic [0:0] chan_t;
	typedef logic [7:0] cmd_t;
	typedef logic [31:0] systime_t;
	typedef logic [31:0] interval_t;
	typedef logic [31:0] count_t;
	typedef logic [31:0] add_t;
	typedef logic signed [31:0] position_t;
	typedef logic [23:0] sample_t;

	// A move is packed as {dir[96], interval[95:64], count[63:32], add[31:0]}
	typedef logic [96:0] move_t;

	localparam cmd_t cmd_config_stepper = 8'h10;
	localparam cmd_t cmd_queue_step = 8'h11;
	localparam cmd_t cmd_set_next_dir = 8'h12;
	localparam cmd_t cmd_reset_step_clock = 8'h13;
	localparam cmd_t cmd_get_pos = 8'h14;
	localparam cmd_t cmd_endstop_set_stepper = 8'h15;
	localparam cmd_t cmd_endstop_query = 8'h16;
	localparam cmd_t cmd_endstop_home = 8'h17;

	localparam logic [31:0] rsp_get_pos = 32'h0000_0081;
	localparam logic [31:0] rsp_endstop_state = 32'h0000_0082;

	localparam int move_depth = 8;
	localparam int move_ptr_w = $clog2(move_depth);

	// Fields of the per-channel configuration register file
	localparam logic [1:0] field_edge = 2'd0;
	localparam logic [1:0] field_dir = 2'd1;
	localparam logic [1:0] field_link = 2'd2;

	// Modular compare, a difference of half the range or more lies in the past
	function automatic logic time_past(systime_t t, systime_t now);
		systime_t diff;
		diff = t - now;
		return diff[31];
	endfunction

endpackage
